//--- src/core_types_pkg.sv
// Core types package
// Sizing constants, the immediate ALU opcode set and the bundles that
// travel between issue, the register file and writeback
`default_nettype none

package core_types_pkg;

  // Register file geometry
  localparam int PRF_BANK_COUNT     = 2;
  localparam int LOG_PRF_BANK_COUNT = 1;
  localparam int PR_COUNT           = 16;
  localparam int LOG_PR_COUNT       = 4;

  // A physical register tag is bank plus index
  localparam int LOG_PR_TAG = LOG_PRF_BANK_COUNT + LOG_PR_COUNT;

  localparam int LOG_ROB_ENTRIES = 4;
  localparam int XLEN            = 32;

  typedef enum logic [3:0] {
    ADDI  = 4'd0,
    SLTI  = 4'd1,
    SLTIU = 4'd2,
    XORI  = 4'd3,
    ORI   = 4'd4,
    ANDI  = 4'd5,
    SLLI  = 4'd6,
    SRLI  = 4'd7,
    SRAI  = 4'd8
  } alu_imm_op_t;

  typedef struct packed {
    alu_imm_op_t                   op;
    logic [11:0]                   imm12;
    logic                          A_forward;
    logic                          A_is_zero;
    logic [LOG_PRF_BANK_COUNT-1:0] A_bank;
    logic [LOG_PR_COUNT-1:0]       A_index;
    logic [LOG_PR_TAG-1:0]         dest_PR;
    logic [LOG_ROB_ENTRIES-1:0]    ROB_index;
  } alu_imm_issue_t;

  typedef struct packed {
    logic [XLEN-1:0]            data;
    logic [LOG_PR_TAG-1:0]      PR;
    logic [LOG_ROB_ENTRIES-1:0] ROB_index;
  } alu_imm_wb_t;

  // Preload write from the APB side
  typedef struct packed {
    logic [LOG_PRF_BANK_COUNT-1:0] bank;
    logic [LOG_PR_COUNT-1:0]       index;
    logic [XLEN-1:0]               data;
  } prf_write_t;

endpackage

`default_nettype wire

//--- src/alu_imm_exec.sv
// Immediate ALU
// Combinational execute unit for the I-type integer operations,
// sign-extended 12-bit immediate, shifts use the low 5 immediate bits
`timescale 1ns/1ps
`default_nettype none

module alu_imm_exec (
  input  core_types_pkg::alu_imm_op_t     op,
  input  logic [core_types_pkg::XLEN-1:0] A,
  input  logic [11:0]                     imm12,
  output logic [core_types_pkg::XLEN-1:0] result
);
  import core_types_pkg::*;

  logic [XLEN-1:0] imm_sext;
  logic [4:0]      shamt;

  assign imm_sext = {{(XLEN-12){imm12[11]}}, imm12};
  assign shamt    = imm12[4:0];

  always_comb begin
    case (op)
      ADDI:  result = A + imm_sext;
      SLTI: begin
        result = {{(XLEN-1){1'b0}}, ($signed(A) < $signed(imm_sext))};
      end
      SLTIU: begin
        result = {{(XLEN-1){1'b0}}, (A < imm_sext)};
      end
      XORI:  result = A ^ imm_sext;
      ORI:   result = A | imm_sext;
      ANDI:  result = A & imm_sext;
      SLLI:  result = A << shamt;
      SRLI:  result = A >> shamt;
      SRAI:  result = $unsigned($signed(A) >>> shamt);
      // Unused opcode codes
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/alu_imm_pipeline.sv
// Immediate ALU pipeline
// Three stages: operand read, execute and writeback. Each stage moves
// only when the next one is empty or moving, so a stalled writeback
// backs up to issue_ready with up to three instructions held
`timescale 1ns/1ps
`default_nettype none

module alu_imm_pipeline (
  input  logic                                             CLK,
  input  logic                                             nRST,
  input  logic                                             issue_valid,
  input  core_types_pkg::alu_imm_issue_t                   issue,
  output logic                                             issue_ready,
  input  logic                                             issue_enable,
  output logic [core_types_pkg::LOG_PRF_BANK_COUNT-1:0]    A_reg_read_req_bank,
  output logic [core_types_pkg::LOG_PR_COUNT-1:0]          A_reg_read_req_index,
  input  logic                                             A_reg_read_ack,
  input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][1:0][core_types_pkg::XLEN-1:0]
                                                           reg_read_data_by_bank_by_port,
  input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][core_types_pkg::XLEN-1:0]
                                                           forward_data_by_bank,
  output logic                                             WB_valid,
  output core_types_pkg::alu_imm_wb_t                      WB,
  input  logic                                             WB_ready
);
  import core_types_pkg::*;

  alu_imm_issue_t  rd_q;
  alu_imm_issue_t  ex_q;
  logic            rd_valid;
  logic            ex_valid;
  logic [XLEN-1:0] rd_A;
  logic [XLEN-1:0] ex_A;
  logic [XLEN-1:0] ex_result;

  logic rd_operand_ok;
  logic rd_move_ok;
  logic ex_move_ok;
  logic wb_move_ok;
  logic issue_fire;
  logic rd_fire;
  logic ex_fire;

  // Register file request comes straight from the read stage
  assign A_reg_read_req_bank  = rd_q.A_bank;
  assign A_reg_read_req_index = rd_q.A_index;

  always_comb begin
    if (rd_q.A_is_zero) begin
      rd_A = '0;
    end else if (rd_q.A_forward) begin
      rd_A = forward_data_by_bank[rd_q.A_bank];
    end else begin
      rd_A = reg_read_data_by_bank_by_port[rd_q.A_bank][0];
    end
  end

  // Only a register file operand has to wait for the ack
  assign rd_operand_ok = rd_q.A_is_zero | rd_q.A_forward | A_reg_read_ack;

  assign wb_move_ok = !WB_valid || WB_ready;
  assign ex_fire    = ex_valid && wb_move_ok;
  assign ex_move_ok = !ex_valid || wb_move_ok;
  assign rd_fire    = rd_valid && rd_operand_ok && ex_move_ok;
  assign rd_move_ok = !rd_valid || (rd_operand_ok && ex_move_ok);

  assign issue_ready = issue_enable && rd_move_ok;
  assign issue_fire  = issue_valid && issue_ready;

  alu_imm_exec u_exec (
    .op     (ex_q.op),
    .A      (ex_A),
    .imm12  (ex_q.imm12),
    .result (ex_result)
  );

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      rd_valid <= 1'b0;
      ex_valid <= 1'b0;
      WB_valid <= 1'b0;
    end else begin
      if (rd_move_ok) begin
        rd_valid <= issue_fire;
      end
      if (ex_move_ok) begin
        ex_valid <= rd_fire;
      end
      if (wb_move_ok) begin
        WB_valid <= ex_fire;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (issue_fire) begin
      rd_q <= issue;
    end
    if (rd_fire) begin
      ex_q <= rd_q;
      ex_A <= rd_A;
    end
    if (ex_fire) begin
      WB.data      <= ex_result;
      WB.PR        <= ex_q.dest_PR;
      WB.ROB_index <= ex_q.ROB_index;
    end
  end

  // A stalled result stays on the port until it is taken
  a_wb_hold: assert property (
    @(posedge CLK) disable iff (!nRST)
    (WB_valid && !WB_ready) |=> (WB_valid && $stable(WB))
  ) else $error("WB changed while stalled");

  // Disabled issue lets no new instruction into the read stage
  a_issue_gated: assert property (
    @(posedge CLK) disable iff (!nRST)
    !issue_enable |=> !$rose(rd_valid)
  ) else $error("Instruction entered the read stage with issue disabled");

endmodule

`default_nettype wire

//--- src/prf_bank_array.sv
// Banked physical register file
// Per-bank storage with two combinational read ports. Port 0 serves the
// ALU operand request, port 1 returns the last preloaded entry of a bank
`timescale 1ns/1ps
`default_nettype none

module prf_bank_array (
  input  logic                                          CLK,
  input  logic                                          nRST,
  input  logic                                          prf_write_valid,
  input  core_types_pkg::prf_write_t                    prf_write,
  input  logic [core_types_pkg::LOG_PRF_BANK_COUNT-1:0] A_reg_read_req_bank,
  input  logic [core_types_pkg::LOG_PR_COUNT-1:0]       A_reg_read_req_index,
  output logic                                          A_reg_read_ack,
  output logic [core_types_pkg::PRF_BANK_COUNT-1:0][1:0][core_types_pkg::XLEN-1:0]
                                                        reg_read_data_by_bank_by_port
);
  import core_types_pkg::*;

  logic [XLEN-1:0]         regs [PRF_BANK_COUNT][PR_COUNT];
  logic [LOG_PR_COUNT-1:0] last_wr_index [PRF_BANK_COUNT];

  // Bank is busy with a preload this cycle
  assign A_reg_read_ack = !(prf_write_valid && (prf_write.bank == A_reg_read_req_bank));

  always_comb begin
    for (int b = 0; b < PRF_BANK_COUNT; b++) begin
      reg_read_data_by_bank_by_port[b][0] = regs[b][A_reg_read_req_index];
      reg_read_data_by_bank_by_port[b][1] = regs[b][last_wr_index[b]];
    end
  end

  always_ff @(posedge CLK) begin
    if (prf_write_valid) begin
      regs[prf_write.bank][prf_write.index] <= prf_write.data;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int b = 0; b < PRF_BANK_COUNT; b++) begin
        last_wr_index[b] <= '0;
      end
    end else if (prf_write_valid) begin
      last_wr_index[prf_write.bank] <= prf_write.index;
    end
  end

endmodule

`default_nettype wire

//--- src/alu_imm_apb_regs.sv
// APB control block for the immediate ALU pipeline
// CTRL enables issue, WB_COUNT counts accepted writebacks and the upper
// half of the map preloads physical registers. Zero wait states
`timescale 1ns/1ps
`default_nettype none

module alu_imm_apb_regs (
  input  logic                                CLK,
  input  logic                                nRST,
  input  logic                                PSEL,
  input  logic                                PENABLE,
  input  logic                                PWRITE,
  input  logic [7:0]                          PADDR,
  input  logic [core_types_pkg::XLEN-1:0]     PWDATA,
  output logic [core_types_pkg::XLEN-1:0]     PRDATA,
  output logic                                PREADY,
  output logic                                PSLVERR,
  input  logic                                WB_valid,
  input  logic                                WB_ready,
  output logic                                issue_enable,
  output logic                                prf_write_valid,
  output core_types_pkg::prf_write_t          prf_write
);
  import core_types_pkg::*;

  localparam logic [7:0] ADDR_CTRL     = 8'h00;
  localparam logic [7:0] ADDR_WB_COUNT = 8'h04;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_t;

  apb_state_t      state;
  logic [XLEN-1:0] wb_count;
  logic            access;
  logic            sel_ctrl;
  logic            sel_count;
  logic            sel_prf;

  // Bus phase tracking, one access per setup
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state <= APB_IDLE;
    end else if (PSEL && !PENABLE) begin
      state <= APB_SETUP;
    end else if (PSEL && state == APB_SETUP) begin
      state <= APB_ACCESS;
    end else begin
      state <= APB_IDLE;
    end
  end

  assign access    = PSEL && PENABLE && (state == APB_SETUP);
  assign sel_ctrl  = (PADDR == ADDR_CTRL);
  assign sel_count = (PADDR == ADDR_WB_COUNT);
  assign sel_prf   = PADDR[7];

  assign PREADY  = 1'b1;
  assign PSLVERR = access && !(sel_ctrl || sel_count || sel_prf);

  always_comb begin
    if (sel_ctrl) begin
      PRDATA = {{(XLEN-1){1'b0}}, issue_enable};
    end else if (sel_count) begin
      PRDATA = wb_count;
    end else begin
      PRDATA = '0;
    end
  end

  // Bit 6 picks the bank, bits 5:2 the register
  assign prf_write_valid = access && PWRITE && sel_prf;
  assign prf_write.bank  = PADDR[6];
  assign prf_write.index = PADDR[5:2];
  assign prf_write.data  = PWDATA;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      issue_enable <= 1'b0;
      wb_count     <= '0;
    end else begin
      if (access && PWRITE && sel_ctrl) begin
        issue_enable <= PWDATA[0];
      end
      if (WB_valid && WB_ready) begin
        wb_count <= wb_count + 1'b1;
      end
    end
  end

  a_penable_psel: assert property (
    @(posedge CLK) disable iff (!nRST)
    PENABLE |-> PSEL
  ) else $error("PENABLE high without PSEL");

endmodule

`default_nettype wire

//--- src/wb_protocol_checker.sv
// Writeback protocol checker
// Watches the issue and writeback ports. Results must hold under stall,
// and with three clean accept cycles the writeback carries the tags
// issued three cycles before
`timescale 1ns/1ps
`default_nettype none

module wb_protocol_checker (
  input logic                           CLK,
  input logic                           nRST,
  input logic                           issue_valid,
  input logic                           issue_ready,
  input core_types_pkg::alu_imm_issue_t issue,
  input logic                           WB_valid,
  input logic                           WB_ready,
  input core_types_pkg::alu_imm_wb_t    WB
);
  import core_types_pkg::*;

  logic [2:0] accept_hist;
  logic [2:0] ready_hist;
  logic       clean_window;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      accept_hist <= '0;
      ready_hist  <= '0;
    end else begin
      accept_hist <= {accept_hist[1:0], issue_valid && issue_ready};
      ready_hist  <= {ready_hist[1:0], WB_ready};
    end
  end

  // Nothing held the pipeline for the last three edges
  assign clean_window = (&accept_hist) && (&ready_hist);

  a_wb_pass_through: assert property (
    @(posedge CLK) disable iff (!nRST)
    clean_window |-> (WB_valid &&
                      WB.PR == $past(issue.dest_PR, 3) &&
                      WB.ROB_index == $past(issue.ROB_index, 3))
  ) else $error("WB tags do not match issue three cycles earlier");

  a_wb_data_hold: assert property (
    @(posedge CLK) disable iff (!nRST)
    (WB_valid && !WB_ready) |=> $stable(WB.data)
  ) else $error("WB data changed during stall");

  a_wb_tags_hold: assert property (
    @(posedge CLK) disable iff (!nRST)
    (WB_valid && !WB_ready) |=> ($stable(WB.PR) && $stable(WB.ROB_index))
  ) else $error("WB tags changed during stall");

endmodule

`default_nettype wire

//--- src/alu_imm_top.sv
// Immediate ALU subsystem top
// Pipeline, banked register file, APB control block and writeback checker
`timescale 1ns/1ps
`default_nettype none

module alu_imm_top (
  input  logic                                  CLK,
  input  logic                                  nRST,
  input  logic                                  issue_valid,
  input  core_types_pkg::alu_imm_issue_t        issue,
  output logic                                  issue_ready,
  input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][core_types_pkg::XLEN-1:0]
                                                forward_data_by_bank,
  output logic                                  WB_valid,
  output core_types_pkg::alu_imm_wb_t           WB,
  input  logic                                  WB_ready,
  input  logic                                  PSEL,
  input  logic                                  PENABLE,
  input  logic                                  PWRITE,
  input  logic [7:0]                            PADDR,
  input  logic [core_types_pkg::XLEN-1:0]       PWDATA,
  output logic [core_types_pkg::XLEN-1:0]       PRDATA,
  output logic                                  PREADY,
  output logic                                  PSLVERR
);
  import core_types_pkg::*;

  logic [LOG_PRF_BANK_COUNT-1:0]                 A_reg_read_req_bank;
  logic [LOG_PR_COUNT-1:0]                       A_reg_read_req_index;
  logic                                          A_reg_read_ack;
  logic [PRF_BANK_COUNT-1:0][1:0][XLEN-1:0]      reg_read_data_by_bank_by_port;
  logic                                          prf_write_valid;
  prf_write_t                                    prf_write;
  logic                                          issue_enable;

  alu_imm_pipeline u_pipeline (
    .CLK                           (CLK),
    .nRST                          (nRST),
    .issue_valid                   (issue_valid),
    .issue                         (issue),
    .issue_ready                   (issue_ready),
    .issue_enable                  (issue_enable),
    .A_reg_read_req_bank           (A_reg_read_req_bank),
    .A_reg_read_req_index          (A_reg_read_req_index),
    .A_reg_read_ack                (A_reg_read_ack),
    .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
    .forward_data_by_bank          (forward_data_by_bank),
    .WB_valid                      (WB_valid),
    .WB                            (WB),
    .WB_ready                      (WB_ready)
  );

  prf_bank_array u_prf (
    .CLK                           (CLK),
    .nRST                          (nRST),
    .prf_write_valid               (prf_write_valid),
    .prf_write                     (prf_write),
    .A_reg_read_req_bank           (A_reg_read_req_bank),
    .A_reg_read_req_index          (A_reg_read_req_index),
    .A_reg_read_ack                (A_reg_read_ack),
    .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port)
  );

  alu_imm_apb_regs u_apb (
    .CLK             (CLK),
    .nRST            (nRST),
    .PSEL            (PSEL),
    .PENABLE         (PENABLE),
    .PWRITE          (PWRITE),
    .PADDR           (PADDR),
    .PWDATA          (PWDATA),
    .PRDATA          (PRDATA),
    .PREADY          (PREADY),
    .PSLVERR         (PSLVERR),
    .WB_valid        (WB_valid),
    .WB_ready        (WB_ready),
    .issue_enable    (issue_enable),
    .prf_write_valid (prf_write_valid),
    .prf_write       (prf_write)
  );

  wb_protocol_checker u_checker (
    .CLK         (CLK),
    .nRST        (nRST),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue       (issue),
    .WB_valid    (WB_valid),
    .WB_ready    (WB_ready),
    .WB          (WB)
  );

endmodule

`default_nettype wire

//--- tests/alu_imm_tb_tasks.svh
// Testbench helpers for the immediate ALU subsystem
// APB read and write access, register preload, instruction issue and
// pipeline drain. All tasks start and end 1 ns after a rising edge
`ifndef ALU_IMM_TB_TASKS_SVH
`define ALU_IMM_TB_TASKS_SVH

task automatic wait_apb_ready();
  int cycles;
  cycles = 0;
  @(negedge CLK);
  while (!PREADY && cycles < APB_TIMEOUT) begin
    @(negedge CLK);
    cycles++;
  end
  if (!PREADY) begin
    timeout_count++;
    $display("Timeout: APB slave did not raise PREADY at address %h", PADDR);
    end_run();
  end
endtask

task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
  PSEL    = 1'b1;
  PENABLE = 1'b0;
  PWRITE  = 1'b1;
  PADDR   = addr;
  PWDATA  = data;
  @(posedge CLK);
  #1;
  PENABLE = 1'b1;
  wait_apb_ready();
  @(posedge CLK);
  #1;
  PSEL    = 1'b0;
  PENABLE = 1'b0;
  PWRITE  = 1'b0;
endtask

task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                        output logic slverr);
  PSEL    = 1'b1;
  PENABLE = 1'b0;
  PWRITE  = 1'b0;
  PADDR   = addr;
  @(posedge CLK);
  #1;
  PENABLE = 1'b1;
  wait_apb_ready();
  // Access phase, sampled before the completing edge
  data   = PRDATA;
  slverr = PSLVERR;
  @(posedge CLK);
  #1;
  PSEL    = 1'b0;
  PENABLE = 1'b0;
endtask

task automatic preload_reg(input int bank, input int index, input logic [31:0] data);
  apb_write({1'b1, 1'(bank), 4'(index), 2'b00}, data);
  prf_image[bank][index] = data;
endtask

task automatic send_instr(input alu_imm_issue_t instr);
  int cycles;
  cycles = 0;
  issue_valid = 1'b1;
  issue       = instr;
  @(negedge CLK);
  while (!issue_ready && cycles < ISSUE_TIMEOUT) begin
    @(negedge CLK);
    cycles++;
  end
  if (!issue_ready) begin
    timeout_count++;
    $display("Timeout: issue_ready stayed low for ROB index %0d", instr.ROB_index);
    end_run();
  end
  @(posedge CLK);
  #1;
  issue_valid = 1'b0;
endtask

task automatic wait_for_drain();
  int cycles;
  cycles = 0;
  while (ref_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
    @(posedge CLK);
    #1;
    cycles++;
  end
  if (ref_q.size() != 0) begin
    timeout_count++;
    $display("Timeout: %0d results never came out of the pipeline", ref_q.size());
    end_run();
  end
endtask

`endif

//--- tests/alu_imm_tb.sv
// Testbench for the immediate ALU subsystem
// Preloads the register file over APB, issues instructions with register,
// forwarded and zero operands and checks every writeback against a
// reference queue, with and without writeback stalls
`timescale 1ns/1ps
`default_nettype none

module alu_imm_tb;
  import core_types_pkg::*;

  localparam int APB_TIMEOUT   = 20;
  localparam int ISSUE_TIMEOUT = 100;
  localparam int DRAIN_TIMEOUT = 400;
  localparam int SRC_REG       = 0;
  localparam int SRC_FWD       = 1;
  localparam int SRC_ZERO      = 2;
  // Accept sampled before edge N, result sampled after edge N+2
  localparam int WB_LATENCY    = 3;

  localparam logic [7:0] CTRL_ADDR     = 8'h00;
  localparam logic [7:0] COUNT_ADDR    = 8'h04;
  localparam logic [7:0] UNMAPPED_ADDR = 8'h40;

  typedef struct packed {
    alu_imm_wb_t wb;
    logic [31:0] accept_cycle;
  } expected_t;

  logic                                     CLK;
  logic                                     nRST;
  logic                                     issue_valid;
  alu_imm_issue_t                           issue;
  logic                                     issue_ready;
  logic [PRF_BANK_COUNT-1:0][XLEN-1:0]      forward_data_by_bank;
  logic                                     WB_valid;
  alu_imm_wb_t                              WB;
  logic                                     WB_ready;
  logic                                     PSEL;
  logic                                     PENABLE;
  logic                                     PWRITE;
  logic [7:0]                               PADDR;
  logic [XLEN-1:0]                          PWDATA;
  logic [XLEN-1:0]                          PRDATA;
  logic                                     PREADY;
  logic                                     PSLVERR;

  logic [XLEN-1:0]         prf_image [PRF_BANK_COUNT][PR_COUNT];
  expected_t               ref_q [$];
  expected_t               ref_head;
  expected_t               accepted;
  logic                    ref_pending;
  logic [31:0]             cycle_count;
  logic [LOG_ROB_ENTRIES-1:0] rob_next;
  logic                    stall_mode;
  logic                    latency_mode;
  logic [31:0]             rdata;
  logic                    slverr;
  int                      error_count;
  int                      timeout_count;
  int                      wb_seen;

  `include "alu_imm_tb_tasks.svh"

  alu_imm_top UUT (
    .CLK                  (CLK),
    .nRST                 (nRST),
    .issue_valid          (issue_valid),
    .issue                (issue),
    .issue_ready          (issue_ready),
    .forward_data_by_bank (forward_data_by_bank),
    .WB_valid             (WB_valid),
    .WB                   (WB),
    .WB_ready             (WB_ready),
    .PSEL                 (PSEL),
    .PENABLE              (PENABLE),
    .PWRITE               (PWRITE),
    .PADDR                (PADDR),
    .PWDATA               (PWDATA),
    .PRDATA               (PRDATA),
    .PREADY               (PREADY),
    .PSLVERR              (PSLVERR)
  );

  initial CLK = 1'b0;
  always #2 CLK = ~CLK;

  task automatic flag_error(input string msg);
    error_count++;
    $display("error %0t: %s", $time, msg);
  endtask

  task automatic expect_value(input string what, input logic [31:0] got,
                              input logic [31:0] want);
    assert (got === want)
      else flag_error($sformatf("%s is %h, expected %h", what, got, want));
  endtask

  task automatic end_run();
    $display("Summary: %0d errors, %0d timeouts, %0d writebacks",
             error_count, timeout_count, wb_seen);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  // Reference ALU built from the ISA rules
  function automatic logic [31:0] predict_result(input alu_imm_op_t op,
                                                 input logic [31:0] a,
                                                 input logic [11:0] imm12);
    logic [31:0] imm;
    logic [4:0]  sh;
    logic [31:0] fill;
    imm  = {{20{imm12[11]}}, imm12};
    sh   = imm12[4:0];
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
    case (op)
      ADDI:    return a + imm;
      SLTI:    return {31'b0, (a[31] != imm[31]) ? a[31] : (a < imm)};
      SLTIU:   return {31'b0, a < imm};
      XORI:    return a ^ imm;
      ORI:     return a | imm;
      ANDI:    return a & imm;
      SLLI:    return a << sh;
      SRLI:    return a >> sh;
      SRAI:    return (a >> sh) | fill;
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] operand_value(input alu_imm_issue_t instr);
    if (instr.A_is_zero) begin
      return 32'h0;
    end
    if (instr.A_forward) begin
      return forward_data_by_bank[instr.A_bank];
    end
    return prf_image[instr.A_bank][instr.A_index];
  endfunction

  function automatic alu_imm_issue_t make_instr(input alu_imm_op_t op, input int src);
    alu_imm_issue_t instr;
    instr.op        = op;
    instr.imm12     = 12'($urandom);
    instr.A_forward = (src == SRC_FWD);
    instr.A_is_zero = (src == SRC_ZERO);
    instr.A_bank    = LOG_PRF_BANK_COUNT'($urandom);
    instr.A_index   = LOG_PR_COUNT'($urandom);
    instr.dest_PR   = LOG_PR_TAG'($urandom);
    instr.ROB_index = rob_next;
    rob_next        = rob_next + 1'b1;
    return instr;
  endfunction

  // Random back-pressure only while stall_mode is set
  always @(posedge CLK) begin
    #1;
    if (stall_mode) begin
      WB_ready = ($urandom_range(0, 2) != 0);
    end else begin
      WB_ready = 1'b1;
    end
  end

  // Sampled mid-cycle where inputs and DUT outputs are settled
  always @(negedge CLK) begin
    if (nRST) begin
      if (WB_valid && WB_ready) begin
        wb_seen++;
        if (latency_mode && ref_q.size() > 0) begin
          assert (cycle_count - ref_q[0].accept_cycle == WB_LATENCY)
            else flag_error($sformatf("ROB %0d written back %0d samples after accept",
                                      WB.ROB_index, cycle_count - ref_q[0].accept_cycle));
        end
        if (ref_q.size() > 0) begin
          void'(ref_q.pop_front());
        end
      end
      if (issue_valid && issue_ready) begin
        accepted.wb.data      = predict_result(issue.op, operand_value(issue), issue.imm12);
        accepted.wb.PR        = issue.dest_PR;
        accepted.wb.ROB_index = issue.ROB_index;
        accepted.accept_cycle = cycle_count;
        ref_q.push_back(accepted);
      end
    end
    ref_pending = (ref_q.size() != 0);
    if (ref_pending) begin
      ref_head = ref_q[0];
    end
    cycle_count = cycle_count + 1;
  end

  a_wb_expected: assert property (
    @(negedge CLK) disable iff (!nRST)
    (WB_valid && WB_ready) |-> (ref_pending && WB == ref_head.wb)
  ) else flag_error($sformatf("WB PR %0d ROB %0d data %h, expected PR %0d ROB %0d data %h",
                              WB.PR, WB.ROB_index, WB.data, $sampled(ref_head.wb.PR),
                              $sampled(ref_head.wb.ROB_index), $sampled(ref_head.wb.data)));

  a_wb_stall_hold: assert property (
    @(negedge CLK) disable iff (!nRST)
    (WB_valid && !WB_ready) |=> (WB_valid && $stable(WB))
  ) else flag_error("WB changed while WB_ready was low");

  initial begin
    void'($urandom(32'h65458a0f));
    nRST                 = 1'b0;
    issue_valid          = 1'b0;
    issue                = '0;
    forward_data_by_bank = '0;
    WB_ready             = 1'b1;
    PSEL                 = 1'b0;
    PENABLE              = 1'b0;
    PWRITE               = 1'b0;
    PADDR                = '0;
    PWDATA               = '0;
    stall_mode           = 1'b0;
    latency_mode         = 1'b0;
    ref_pending          = 1'b0;
    ref_head             = '0;
    cycle_count          = '0;
    rob_next             = '0;
    error_count          = 0;
    timeout_count        = 0;
    wb_seen              = 0;
    repeat (10) @(posedge CLK);
    #1;
    nRST = 1'b1;

    @(negedge CLK);
    expect_value("WB_valid after reset", WB_valid, 0);
    expect_value("issue_ready after reset", issue_ready, 0);
    expect_value("PSLVERR after reset", PSLVERR, 0);
    @(posedge CLK);
    #1;
    apb_read(COUNT_ADDR, rdata, slverr);
    expect_value("WB_COUNT after reset", rdata, 0);
    expect_value("PSLVERR on WB_COUNT", slverr, 0);
    apb_read(UNMAPPED_ADDR, rdata, slverr);
    expect_value("PSLVERR on unmapped address", slverr, 1);

    for (int b = 0; b < PRF_BANK_COUNT; b++) begin
      for (int i = 0; i < PR_COUNT; i++) begin
        preload_reg(b, i, $urandom);
      end
    end
    apb_write(CTRL_ADDR, 32'h1);

    // Every opcode on a register operand
    for (int op = 0; op < 9; op++) begin
      send_instr(make_instr(alu_imm_op_t'(op), SRC_REG));
    end
    wait_for_drain();

    for (int round = 0; round < 2; round++) begin
      forward_data_by_bank[0] = $urandom;
      forward_data_by_bank[1] = $urandom;
      for (int op = 0; op < 9; op++) begin
        send_instr(make_instr(alu_imm_op_t'(op), (op % 2 == round) ? SRC_FWD : SRC_ZERO));
      end
      wait_for_drain();
    end

    // Back-to-back issue with the port always ready
    latency_mode = 1'b1;
    repeat (12) send_instr(make_instr(alu_imm_op_t'($urandom_range(0, 8)),
                                      $urandom_range(0, 2)));
    wait_for_drain();
    latency_mode = 1'b0;

    stall_mode = 1'b1;
    repeat (40) send_instr(make_instr(alu_imm_op_t'($urandom_range(0, 8)),
                                      $urandom_range(0, 2)));
    wait_for_drain();
    stall_mode = 1'b0;
    @(posedge CLK);
    #1;

    apb_read(COUNT_ADDR, rdata, slverr);
    expect_value("WB_COUNT after run", rdata, wb_seen);
    apb_write(CTRL_ADDR, 32'h0);
    issue_valid = 1'b1;
    issue       = make_instr(ADDI, SRC_ZERO);
    @(negedge CLK);
    expect_value("issue_ready with issue disabled", issue_ready, 0);
    @(posedge CLK);
    #1;
    issue_valid = 1'b0;
    expect_value("results left in reference queue", ref_q.size(), 0);
    end_run();
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+tests
src/core_types_pkg.sv
src/alu_imm_exec.sv
src/alu_imm_pipeline.sv
src/prf_bank_array.sv
src/alu_imm_apb_regs.sv
src/wb_protocol_checker.sv
src/alu_imm_top.sv
tests/alu_imm_tb.sv
